// ==== all.f ====
design/cache_geom_pkg.sv
design/cache_msg_pkg.sv
design/cache_sram.sv
design/cache_dpath.sv
design/cache_ctrl.sv
design/blocking_cache.sv
test/mem_model.sv
test/tb_blocking_cache.sv

// ==== Makefile ====
# Verilator build and run for the blocking cache testbench

VERILATOR ?= verilator
TOP       ?= tb_blocking_cache
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Simulation failed

SIM_BIN  = $(BUILD_DIR)/V$(TOP)
SOURCES  = $(wildcard design/*.sv) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_blocking_cache.sv ====
/*
 * Blocking cache testbench: clock, reset, LFSR stimulus, reference
 * word memory, response compare, watchdog and summary
 */
`timescale 1ns/100ps
`default_nettype none

module tb_blocking_cache
  import cache_geom_pkg::*, cache_msg_pkg::*;
;

  localparam logic [31:0] lfsr_seed       = 32'hde45_1180;
  localparam logic [31:0] pattern_xor     = 32'h5a5a_0000;
  localparam int          num_directed    = 13;
  localparam int          num_random      = 300;
  localparam int          resp_timeout    = 200;
  localparam int          watchdog_cycles = (num_directed + num_random) * 40;

  logic                    clk;
  logic                    rst_n;
  logic                    cachereq_val;
  logic [type_nbits-1:0]   cachereq_type;
  logic [opaque_nbits-1:0] cachereq_opaque;
  logic [addr_nbits-1:0]   cachereq_addr;
  logic [data_nbits-1:0]   cachereq_data;
  logic                    busy;
  logic                    cacheresp_val;
  logic [type_nbits-1:0]   cacheresp_type;
  logic [opaque_nbits-1:0] cacheresp_opaque;
  logic [data_nbits-1:0]   cacheresp_data;
  logic                    memreq_val;
  logic [type_nbits-1:0]   memreq_type;
  logic [addr_nbits-1:0]   memreq_addr;
  logic [line_nbits-1:0]   memreq_data;
  logic                    memresp_val;
  logic [line_nbits-1:0]   memresp_data;
  logic [3:0]              mem_latency;

  logic [31:0]             lfsr_state;
  logic [opaque_nbits-1:0] next_opaque;
  logic [31:0]             cur_addr;
  logic [31:0]             ref_mem [logic [31:0]];
  logic [type_nbits-1:0]   exp_type_q[$];
  logic [opaque_nbits-1:0] exp_opaque_q[$];
  logic [data_nbits-1:0]   exp_data_q[$];
  logic                    exp_read_q[$];
  int                      n_checks = 0;
  int                      n_errors = 0;
  int                      n_tests = 0;
  int                      tests_failed = 0;
  int                      resp_count = 0;
  int                      memreq_count = 0;
  time                     last_resp_time = 0;

  blocking_cache i_blocking_cache (.*);

  mem_model i_mem_model (
    .clk          (clk),
    .rst_n        (rst_n),
    .memreq_val   (memreq_val),
    .memreq_type  (memreq_type),
    .memreq_addr  (memreq_addr),
    .memreq_data  (memreq_data),
    .latency      (mem_latency),
    .memresp_val  (memresp_val),
    .memresp_data (memresp_data)
  );

  always #10 clk = ~clk;

  //--------------------------------------------------
  // Random source and reference model
  //--------------------------------------------------

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hd000_0001;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // Last written value, or the initial memory pattern
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [31:0] word_addr;
    word_addr = {addr[31:2], 2'b00};
    if (ref_mem.exists(word_addr)) begin
      return ref_mem[word_addr];
    end
    return word_addr ^ pattern_xor;
  endfunction

  //--------------------------------------------------
  // Checks and request driver
  //--------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Refill asks for the requested line and eviction writes back the old line of that index
  task automatic compare_memreq();
    if (memreq_type == msg_read) begin
      check_value("memreq_addr", memreq_addr, {cur_addr[31:4], 4'h0});
    end else begin
      check_value("memreq_type", 32'(memreq_type), 32'(msg_write));
      check_value("memreq_addr offset", 32'(memreq_addr[3:0]), 32'd0);
      check_value("memreq_addr index", 32'(memreq_addr[7:4]), 32'(cur_addr[7:4]));
      for (int w = 0; w < 4; w++) begin
        check_value("memreq_data", memreq_data[w*32 +: 32],
                    expected_word({memreq_addr[31:4], 4'h0} + 32'(w * 4)));
      end
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    n_tests++;
    if (n_errors == errors_before) begin
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s (%0d errors)", name, n_errors - errors_before);
    end
  endtask

  // Called at the drive point, returns once the response has been seen
  task automatic do_request(input logic [type_nbits-1:0] typ, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] lat,
                            output int cycles, output int nmem);
    int  resp_before;
    int  mem_before;
    int  waited;
    time t_accept;
    while (busy) begin
      @(posedge clk);
      #2;
    end
    cachereq_val    = 1'b1;
    cachereq_type   = typ;
    cachereq_opaque = next_opaque;
    cachereq_addr   = addr;
    cachereq_data   = data;
    mem_latency     = lat;
    cur_addr        = addr;
    exp_type_q.push_back(typ);
    exp_opaque_q.push_back(next_opaque);
    exp_read_q.push_back(typ == msg_read);
    exp_data_q.push_back(expected_word(addr));
    if (typ == msg_write) begin
      ref_mem[{addr[31:2], 2'b00}] = data;
    end
    next_opaque = next_opaque + 8'd1;
    resp_before = resp_count;
    mem_before  = memreq_count;
    @(posedge clk);
    t_accept = $time;
    #2;
    cachereq_val = 1'b0;
    waited       = 0;
    while (resp_count == resp_before && waited < resp_timeout) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (resp_count == resp_before) begin
      n_errors++;
      $display("ERROR: no response for address %h after %0d cycles", addr, waited);
    end
    // Edges from acceptance to the end of the response cycle
    cycles = int'((last_resp_time - t_accept + 10) / 20);
    nmem   = memreq_count - mem_before;
  endtask

  // Outputs are sampled mid-cycle, away from the edges
  always @(negedge clk) begin
    logic [data_nbits-1:0] e_data;
    logic                  e_read;
    if (rst_n && memreq_val) begin
      memreq_count++;
      compare_memreq();
    end
    if (rst_n && cacheresp_val) begin
      resp_count++;
      last_resp_time = $time;
      if (exp_type_q.size() == 0) begin
        n_errors++;
        $display("ERROR: response seen with no request outstanding");
      end else begin
        check_value("cacheresp_type", 32'(cacheresp_type), 32'(exp_type_q.pop_front()));
        check_value("cacheresp_opaque", 32'(cacheresp_opaque),
                    32'(exp_opaque_q.pop_front()));
        e_data = exp_data_q.pop_front();
        e_read = exp_read_q.pop_front();
        if (e_read) begin
          check_value("cacheresp_data", cacheresp_data, e_data);
        end
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles", watchdog_cycles);
    $display("Simulation failed");
    $finish;
  end

  //--------------------------------------------------
  // Test sequence
  //--------------------------------------------------

  initial begin
    int          errs;
    int          cycles;
    int          nmem;
    logic [31:0] r_line;
    logic [31:0] r_word;
    logic [31:0] r_type;
    logic [31:0] r_data;
    logic [31:0] r_lat;
    clk             = 1'b0;
    rst_n           = 1'b0;
    cachereq_val    = 1'b0;
    cachereq_type   = msg_read;
    cachereq_opaque = '0;
    cachereq_addr   = '0;
    cachereq_data   = '0;
    mem_latency     = 4'd2;
    next_opaque     = 8'h10;
    cur_addr        = '0;
    lfsr_state      = lfsr_seed;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    errs = n_errors;
    check_value("busy", 32'(busy), 32'd0);
    check_value("cacheresp_val", 32'(cacheresp_val), 32'd0);
    check_value("memreq_val", 32'(memreq_val), 32'd0);
    do_request(msg_read, 32'h0000_0040, 32'h0, 4'd2, cycles, nmem);
    check_value("memreq_val count", nmem, 1);
    end_test("reset state", errs);

    errs = n_errors;
    do_request(msg_read, 32'h0000_1000, 32'h0, 4'd2, cycles, nmem);
    check_value("memreq_val count", nmem, 1);
    do_request(msg_read, 32'h0000_2014, 32'h0, 4'd3, cycles, nmem);
    check_value("memreq_val count", nmem, 1);
    do_request(msg_read, 32'h0000_302c, 32'h0, 4'd1, cycles, nmem);
    check_value("memreq_val count", nmem, 1);
    end_test("cold read misses", errs);

    errs = n_errors;
    do_request(msg_read, 32'h0000_2018, 32'h0, 4'd2, cycles, nmem);
    check_value("cacheresp_val latency", cycles, 3);
    check_value("memreq_val count", nmem, 0);
    do_request(msg_read, 32'h0000_2014, 32'h0, 4'd2, cycles, nmem);
    check_value("cacheresp_val latency", cycles, 3);
    end_test("read hits", errs);

    errs = n_errors;
    do_request(msg_write, 32'h0000_3028, 32'hcafe_f00d, 4'd2, cycles, nmem);
    for (int w = 0; w < 4; w++) begin
      do_request(msg_read, 32'h0000_3020 + 32'(w * 4), 32'h0, 4'd2, cycles, nmem);
    end
    end_test("write then read", errs);

    // Same index as the dirty line, different tag
    errs = n_errors;
    do_request(msg_read, 32'h0000_4024, 32'h0, 4'd3, cycles, nmem);
    check_value("memreq_val count", nmem, 2);
    check_value("memory word 0x3028", i_mem_model.peek_word(32'h0000_3028), 32'hcafe_f00d);
    do_request(msg_read, 32'h0000_3028, 32'h0, 4'd2, cycles, nmem);
    check_value("memreq_val count", nmem, 1);
    end_test("dirty eviction", errs);

    errs = n_errors;
    for (int i = 0; i < num_random; i++) begin
      r_line = rand_bits(6);
      r_word = rand_bits(2);
      r_type = rand_bits(1);
      r_data = rand_bits(32);
      r_lat  = rand_bits(3);
      do_request(r_type[0] ? msg_write : msg_read,
                 {22'b0, r_line[5:0], r_word[1:0], 2'b00}, r_data,
                 {1'b0, r_lat[2:0]} + 4'd1, cycles, nmem);
    end
    end_test("random mix", errs);

    if (exp_type_q.size() != 0) begin
      n_errors++;
      $display("ERROR: %0d responses never arrived", exp_type_q.size());
    end
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, tests_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/mem_model.sv ====
/*
 * Line-wide behavioural memory with per-request latency
 * and an address-derived initial pattern
 */
`timescale 1ns/100ps
`default_nettype none

module mem_model
  import cache_geom_pkg::*, cache_msg_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  memreq_val,
  input  logic [type_nbits-1:0] memreq_type,
  input  logic [addr_nbits-1:0] memreq_addr,
  input  logic [line_nbits-1:0] memreq_data,
  input  logic [3:0]            latency,
  output logic                  memresp_val,
  output logic [line_nbits-1:0] memresp_data
);

  localparam logic [31:0] pattern_xor = 32'h5a5a_0000;

  // Only lines written back are stored, the rest follow the pattern
  logic [line_nbits-1:0] lines [logic [27:0]];
  logic [line_nbits-1:0] pending_data;
  logic                  pending;
  logic [3:0]            wait_cnt;

  function automatic logic [line_nbits-1:0] read_line(input logic [27:0] line_num);
    logic [line_nbits-1:0] line;
    if (lines.exists(line_num)) begin
      return lines[line_num];
    end
    for (int w = 0; w < line_nbits / data_nbits; w++) begin
      line[w*data_nbits +: data_nbits] = {line_num, w[1:0], 2'b00} ^ pattern_xor;
    end
    return line;
  endfunction

  function automatic logic [31:0] peek_word(input logic [31:0] addr);
    logic [line_nbits-1:0] line;
    line = read_line(addr[31:4]);
    return line[addr[3:2]*data_nbits +: data_nbits];
  endfunction

  // Response edge comes latency edges after the request edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memresp_val  <= 1'b0;
      memresp_data <= '0;
      pending      <= 1'b0;
      pending_data <= '0;
      wait_cnt     <= 4'd0;
    end else begin
      memresp_val <= 1'b0;
      if (memreq_val) begin
        pending  <= 1'b1;
        wait_cnt <= latency;
        if (memreq_type == msg_write) begin
          lines[memreq_addr[31:4]] = memreq_data;
          pending_data <= '0;
        end else begin
          pending_data <= read_line(memreq_addr[31:4]);
        end
      end else if (pending) begin
        if (wait_cnt <= 4'd1) begin
          memresp_val  <= 1'b1;
          memresp_data <= pending_data;
          pending      <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 4'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/blocking_cache.sv ====
/*
 * Blocking cache top: controller, datapath, tag and data arrays
 */
`timescale 1ns/100ps
`default_nettype none

module blocking_cache
  import cache_geom_pkg::*, cache_msg_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,

  // Processor side
  input  logic                    cachereq_val,
  input  logic [type_nbits-1:0]   cachereq_type,
  input  logic [opaque_nbits-1:0] cachereq_opaque,
  input  logic [addr_nbits-1:0]   cachereq_addr,
  input  logic [data_nbits-1:0]   cachereq_data,
  output logic                    busy,
  output logic                    cacheresp_val,
  output logic [type_nbits-1:0]   cacheresp_type,
  output logic [opaque_nbits-1:0] cacheresp_opaque,
  output logic [data_nbits-1:0]   cacheresp_data,

  // Memory side
  output logic                    memreq_val,
  output logic [type_nbits-1:0]   memreq_type,
  output logic [addr_nbits-1:0]   memreq_addr,
  output logic [line_nbits-1:0]   memreq_data,
  input  logic                    memresp_val,
  input  logic [line_nbits-1:0]   memresp_data
);

  logic                      cachereq_en;
  logic                      memresp_en;
  logic                      tag_array_ren;
  logic                      tag_array_wen;
  logic                      data_array_ren;
  logic                      data_array_wen;
  logic [wben_nbits-1:0]     data_array_wben;
  logic                      write_data_mux_sel;
  logic                      evict_addr_reg_en;
  logic                      memreq_addr_mux_sel;
  logic                      read_data_reg_en;
  logic                      read_word_sel;
  logic                      tag_match;
  logic [type_nbits-1:0]     cachereq_type_q;
  logic [idx_nbits-1:0]      req_idx;
  logic [word_off_nbits-1:0] req_word_off;
  logic [tag_nbits-1:0]      tag_read_data;
  logic [tag_nbits-1:0]      tag_write_data;
  logic [line_nbits-1:0]     data_read_data;
  logic [line_nbits-1:0]     data_write_data;

  cache_ctrl i_cache_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .cachereq_val        (cachereq_val),
    .memresp_val         (memresp_val),
    .tag_match           (tag_match),
    .cachereq_type_q     (cachereq_type_q),
    .req_idx             (req_idx),
    .req_word_off        (req_word_off),
    .busy                (busy),
    .cacheresp_val       (cacheresp_val),
    .cacheresp_type      (cacheresp_type),
    .memreq_val          (memreq_val),
    .memreq_type         (memreq_type),
    .cachereq_en         (cachereq_en),
    .memresp_en          (memresp_en),
    .tag_array_ren       (tag_array_ren),
    .tag_array_wen       (tag_array_wen),
    .data_array_ren      (data_array_ren),
    .data_array_wen      (data_array_wen),
    .data_array_wben     (data_array_wben),
    .write_data_mux_sel  (write_data_mux_sel),
    .evict_addr_reg_en   (evict_addr_reg_en),
    .memreq_addr_mux_sel (memreq_addr_mux_sel),
    .read_data_reg_en    (read_data_reg_en),
    .read_word_sel       (read_word_sel)
  );

  cache_dpath i_cache_dpath (
    .clk                 (clk),
    .rst_n               (rst_n),
    .cachereq_type       (cachereq_type),
    .cachereq_opaque     (cachereq_opaque),
    .cachereq_addr       (cachereq_addr),
    .cachereq_data       (cachereq_data),
    .memresp_data        (memresp_data),
    .cachereq_en         (cachereq_en),
    .memresp_en          (memresp_en),
    .write_data_mux_sel  (write_data_mux_sel),
    .evict_addr_reg_en   (evict_addr_reg_en),
    .memreq_addr_mux_sel (memreq_addr_mux_sel),
    .read_data_reg_en    (read_data_reg_en),
    .read_word_sel       (read_word_sel),
    .tag_read_data       (tag_read_data),
    .data_read_data      (data_read_data),
    .tag_match           (tag_match),
    .cachereq_type_q     (cachereq_type_q),
    .req_idx             (req_idx),
    .req_word_off        (req_word_off),
    .tag_write_data      (tag_write_data),
    .data_write_data     (data_write_data),
    .cacheresp_opaque    (cacheresp_opaque),
    .cacheresp_data      (cacheresp_data),
    .memreq_addr         (memreq_addr),
    .memreq_data         (memreq_data)
  );

  // Tags are always written whole
  cache_sram #(.width(tag_nbits), .depth(nlines)) tag_array (
    .clk           (clk),
    .rst_n         (rst_n),
    .read_en       (tag_array_ren),
    .read_addr     (req_idx),
    .read_data     (tag_read_data),
    .write_en      (tag_array_wen),
    .write_byte_en ({(tag_nbits/8){1'b1}}),
    .write_addr    (req_idx),
    .write_data    (tag_write_data)
  );

  cache_sram #(.width(line_nbits), .depth(nlines)) data_array (
    .clk           (clk),
    .rst_n         (rst_n),
    .read_en       (data_array_ren),
    .read_addr     (req_idx),
    .read_data     (data_read_data),
    .write_en      (data_array_wen),
    .write_byte_en (data_array_wben),
    .write_addr    (req_idx),
    .write_data    (data_write_data)
  );

endmodule

`default_nettype wire

// ==== design/cache_ctrl.sv ====
/*
 * Blocking cache controller: miss FSM, valid and dirty bits,
 * datapath and array strobes
 */
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl
  import cache_geom_pkg::*, cache_msg_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      cachereq_val,
  input  logic                      memresp_val,

  // Status from the datapath
  input  logic                      tag_match,
  input  logic [type_nbits-1:0]     cachereq_type_q,
  input  logic [idx_nbits-1:0]      req_idx,
  input  logic [word_off_nbits-1:0] req_word_off,

  // Port handshakes
  output logic                      busy,
  output logic                      cacheresp_val,
  output logic [type_nbits-1:0]     cacheresp_type,
  output logic                      memreq_val,
  output logic [type_nbits-1:0]     memreq_type,

  // Datapath and array strobes
  output logic                      cachereq_en,
  output logic                      memresp_en,
  output logic                      tag_array_ren,
  output logic                      tag_array_wen,
  output logic                      data_array_ren,
  output logic                      data_array_wen,
  output logic [wben_nbits-1:0]     data_array_wben,
  output logic                      write_data_mux_sel,
  output logic                      evict_addr_reg_en,
  output logic                      memreq_addr_mux_sel,
  output logic                      read_data_reg_en,
  output logic                      read_word_sel
);

  enum logic [3:0] {
    idle, tag_check, evict_req, evict_wait, refill_req,
    refill_wait, refill_update, access, resp
  } state, state_next;

  logic [nlines-1:0] valid_bits;
  logic [nlines-1:0] dirty_bits;
  logic              is_write;
  logic              hit;
  logic              line_dirty;

  assign is_write   = (cachereq_type_q == msg_write);
  assign hit        = tag_match && valid_bits[req_idx];
  assign line_dirty = valid_bits[req_idx] && dirty_bits[req_idx];

  //--------------------------------------------------
  // Miss FSM
  //--------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      idle:          if (cachereq_val) state_next = tag_check;
      tag_check: begin
        if (hit)             state_next = access;
        else if (line_dirty) state_next = evict_req;
        else                 state_next = refill_req;
      end
      evict_req:     state_next = evict_wait;
      evict_wait:    if (memresp_val) state_next = refill_req;
      refill_req:    state_next = refill_wait;
      refill_wait:   if (memresp_val) state_next = refill_update;
      refill_update: state_next = access;
      access:        state_next = resp;
      resp:          state_next = idle;
      default:       state_next = idle;
    endcase
  end

  //--------------------------------------------------
  // Valid and dirty bits
  //--------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (state == refill_update) begin
        valid_bits[req_idx] <= 1'b1;
        dirty_bits[req_idx] <= 1'b0;
      end
      if (state == access && is_write) begin
        dirty_bits[req_idx] <= 1'b1;
      end
    end
  end

  //--------------------------------------------------
  // Strobes
  //--------------------------------------------------

  assign busy        = (state != idle);
  assign cachereq_en = (state == idle) && cachereq_val;

  // Tag check also captures the line and victim address in case of eviction
  assign tag_array_ren     = (state == tag_check);
  assign evict_addr_reg_en = (state == tag_check);
  assign data_array_ren    = (state == tag_check) || (state == access);
  assign read_data_reg_en  = (state == tag_check) || (state == access);

  assign memreq_val          = (state == evict_req) || (state == refill_req);
  assign memreq_type         = (state == evict_req) ? msg_write : msg_read;
  assign memreq_addr_mux_sel = (state == refill_req);
  assign memresp_en          = (state == refill_wait) && memresp_val;

  assign tag_array_wen      = (state == refill_update);
  assign write_data_mux_sel = (state == refill_update);
  assign data_array_wen     = (state == refill_update) || (state == access && is_write);

  // Whole line on refill, the addressed word's bytes on a write
  assign data_array_wben = (state == refill_update) ? {wben_nbits{1'b1}}
      : {{(wben_nbits - data_nbits/8){1'b0}}, {(data_nbits/8){1'b1}}}
        << (req_word_off * (data_nbits/8));

  assign cacheresp_val  = (state == resp);
  assign cacheresp_type = is_write ? msg_write : msg_read;
  assign read_word_sel  = (state == resp) && !is_write;

endmodule

`default_nettype wire

// ==== design/cache_dpath.sv ====
/*
 * Cache datapath: request and refill registers, tag compare,
 * array write data, evict and refill addresses, word select
 */
`timescale 1ns/100ps
`default_nettype none

module cache_dpath
  import cache_geom_pkg::*, cache_msg_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,

  // Processor request and memory response payloads
  input  logic [type_nbits-1:0]     cachereq_type,
  input  logic [opaque_nbits-1:0]   cachereq_opaque,
  input  logic [addr_nbits-1:0]     cachereq_addr,
  input  logic [data_nbits-1:0]     cachereq_data,
  input  logic [line_nbits-1:0]     memresp_data,

  // Controller strobes
  input  logic                      cachereq_en,
  input  logic                      memresp_en,
  input  logic                      write_data_mux_sel,
  input  logic                      evict_addr_reg_en,
  input  logic                      memreq_addr_mux_sel,
  input  logic                      read_data_reg_en,
  input  logic                      read_word_sel,

  // Array read data
  input  logic [tag_nbits-1:0]      tag_read_data,
  input  logic [line_nbits-1:0]     data_read_data,

  // Status to the controller
  output logic                      tag_match,
  output logic [type_nbits-1:0]     cachereq_type_q,
  output logic [idx_nbits-1:0]      req_idx,
  output logic [word_off_nbits-1:0] req_word_off,

  // Array write data
  output logic [tag_nbits-1:0]      tag_write_data,
  output logic [line_nbits-1:0]     data_write_data,

  // Response and memory request payloads
  output logic [opaque_nbits-1:0]   cacheresp_opaque,
  output logic [data_nbits-1:0]     cacheresp_data,
  output logic [addr_nbits-1:0]     memreq_addr,
  output logic [line_nbits-1:0]     memreq_data
);

  cache_addr_t               req_addr;
  cache_addr_t               refill_addr;
  cache_addr_t               evict_addr_next;
  logic [addr_nbits-1:0]     evict_addr;
  logic [data_nbits-1:0]     req_data;
  logic [opaque_nbits-1:0]   req_opaque;
  logic [line_nbits-1:0]     refill_line;
  logic [line_nbits-1:0]     read_line;

  //--------------------------------------------------
  // Request and refill registers
  //--------------------------------------------------

  always_ff @(posedge clk) begin
    if (cachereq_en) begin
      cachereq_type_q <= cachereq_type;
      req_opaque      <= cachereq_opaque;
      req_addr        <= cachereq_addr;
      req_data        <= cachereq_data;
    end
  end

  always_ff @(posedge clk) begin
    if (memresp_en) begin
      refill_line <= memresp_data;
    end
  end

  //--------------------------------------------------
  // Lookup
  //--------------------------------------------------

  assign req_idx        = req_addr.fields.idx;
  assign req_word_off   = req_addr.fields.word_off;
  assign tag_match      = (req_addr.fields.tag == tag_read_data);
  assign tag_write_data = req_addr.fields.tag;

  // Processor word lands in every slot, byte enables pick the one written
  assign data_write_data = write_data_mux_sel ? refill_line
                                              : {(line_nbits/data_nbits){req_data}};

  //--------------------------------------------------
  // Memory addresses
  //--------------------------------------------------

  // Victim line address from the stored tag
  always_comb begin
    evict_addr_next            = '0;
    evict_addr_next.fields.tag = tag_read_data;
    evict_addr_next.fields.idx = req_addr.fields.idx;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      evict_addr <= '0;
    end else if (evict_addr_reg_en) begin
      evict_addr <= evict_addr_next;
    end
  end

  // Refill is line aligned
  always_comb begin
    refill_addr               = req_addr;
    refill_addr.line.line_off = '0;
  end

  assign memreq_addr = memreq_addr_mux_sel ? refill_addr : evict_addr;

  //--------------------------------------------------
  // Read data and word select
  //--------------------------------------------------

  always_ff @(posedge clk) begin
    if (read_data_reg_en) begin
      read_line <= data_read_data;
    end
  end

  // Evicted line goes out of the same register
  assign memreq_data = read_line;

  assign cacheresp_opaque = req_opaque;
  assign cacheresp_data   = read_word_sel ? read_line[req_word_off*data_nbits +: data_nbits]
                                          : '0;

endmodule

`default_nettype wire

// ==== design/cache_sram.sv ====
/*
 * Single-port array with combinational read and byte-enabled
 * registered write
 */
`timescale 1ns/100ps
`default_nettype none

module cache_sram #(
  parameter int width = 128,
  parameter int depth = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     read_en,
  input  logic [$clog2(depth)-1:0] read_addr,
  output logic [width-1:0]         read_data,
  input  logic                     write_en,
  input  logic [width/8-1:0]       write_byte_en,
  input  logic [$clog2(depth)-1:0] write_addr,
  input  logic [width-1:0]         write_data
);

  logic [width-1:0] mem [depth];

  // Reads return zero when not enabled
  assign read_data = read_en ? mem[read_addr] : '0;

  // No writes land while reset is held
  always_ff @(posedge clk) begin
    if (rst_n && write_en) begin
      for (int i = 0; i < width / 8; i++) begin
        if (write_byte_en[i]) begin
          mem[write_addr][i*8 +: 8] <= write_data[i*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/cache_msg_pkg.sv ====
/*
 * Message field widths and type codes for the processor
 * and memory ports
 */
`default_nettype none

package cache_msg_pkg;

  //--------------------------------------------------
  // Field widths
  //--------------------------------------------------

  localparam int type_nbits   = 3;
  localparam int opaque_nbits = 8;

  //--------------------------------------------------
  // Type codes
  //--------------------------------------------------

  // Same codes on the processor and memory sides
  localparam logic [type_nbits-1:0] msg_read  = 3'd0;
  localparam logic [type_nbits-1:0] msg_write = 3'd1;

endpackage

`default_nettype wire

// ==== design/cache_geom_pkg.sv ====
/*
 * Cache geometry constants and the request address union
 */
`default_nettype none

package cache_geom_pkg;

  localparam int addr_nbits     = 32;
  localparam int data_nbits     = 32;
  localparam int line_nbits     = 128;
  localparam int nlines         = 16;
  localparam int idx_nbits      = 4;
  localparam int tag_nbits      = 24;
  localparam int wben_nbits     = 16;

  // Offset fields inside a byte address
  localparam int word_off_nbits = 2;
  localparam int byte_off_nbits = 2;
  localparam int line_off_nbits = word_off_nbits + byte_off_nbits;

  // Lookup view and line-aligned view of the same address word
  typedef union packed {
    struct packed {
      logic [tag_nbits-1:0]      tag;
      logic [idx_nbits-1:0]      idx;
      logic [word_off_nbits-1:0] word_off;
      logic [byte_off_nbits-1:0] byte_off;
    } fields;
    struct packed {
      logic [addr_nbits-line_off_nbits-1:0] line_num;
      logic [line_off_nbits-1:0]            line_off;
    } line;
  } cache_addr_t;

endpackage

`default_nettype wire
